// File: cdb.f
+incdir+logic
logic/cdb_pkg.sv
logic/prio_enc_inv.sv
logic/cdb_arbiter.sv
logic/cdb_mux.sv
logic/cdb.sv
test/cdb_checker.sv
test/tb_cdb.sv

// File: logic/cdb.sv
// Common data bus: arbitrates finished results and forwards one per cycle to the ROB
`timescale 1ns/1ps

module cdb
  import cdb_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     flush_i,

  // Max-priority unit
  input  logic                     max_prio_valid_i,
  output logic                     max_prio_ready_o,
  input  cdb_data_t                max_prio_data_i,
  input  rob_tag_t                 max_prio_tag_i,
  input  logic                     max_prio_except_i,

  // Arbitrated units
  input  eu_mask_t                 eu_valid_i,
  output eu_mask_t                 eu_ready_o,
  input  cdb_data_t [EU_ARB_N-1:0] eu_data_i,
  input  rob_tag_t  [EU_ARB_N-1:0] eu_tag_i,
  input  eu_mask_t                 eu_except_i,

  // ROB and bus listeners
  input  logic                     rob_ready_i,
  output logic                     rob_valid_o,
  output cdb_data_t                cdb_data_o,
  output rob_tag_t                 cdb_tag_o,
  output logic                     cdb_except_o
);

  // Arbiter to mux selection
  logic    served_max_prio;
  eu_idx_t served_idx;

  // ----------------------------------------------------------
  // Arbiter
  // ----------------------------------------------------------

  cdb_arbiter i_arbiter (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .flush_i           (flush_i),
    .max_prio_valid_i  (max_prio_valid_i),
    .max_prio_ready_o  (max_prio_ready_o),
    .eu_valid_i        (eu_valid_i),
    .eu_ready_o        (eu_ready_o),
    .rob_ready_i       (rob_ready_i),
    .rob_valid_o       (rob_valid_o),
    .served_max_prio_o (served_max_prio),
    .served_idx_o      (served_idx)
  );

  // ----------------------------------------------------------
  // Payload mux
  // ----------------------------------------------------------

  cdb_mux i_mux (
    .max_prio_data_i   (max_prio_data_i),
    .max_prio_tag_i    (max_prio_tag_i),
    .max_prio_except_i (max_prio_except_i),
    .eu_data_i         (eu_data_i),
    .eu_tag_i          (eu_tag_i),
    .eu_except_i       (eu_except_i),
    .served_max_prio_i (served_max_prio),
    .served_idx_i      (served_idx),
    .cdb_data_o        (cdb_data_o),
    .cdb_tag_o         (cdb_tag_o),
    .cdb_except_o      (cdb_except_o)
  );

endmodule

// File: logic/cdb_arbiter.sv
// CDB arbiter: round-based grant over the units with a max-priority override
`timescale 1ns/1ps

module cdb_arbiter
  import cdb_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,

  // Max-priority unit handshake
  input  logic     max_prio_valid_i,
  output logic     max_prio_ready_o,

  // Arbitrated unit handshakes, one bit per unit
  input  eu_mask_t eu_valid_i,
  output eu_mask_t eu_ready_o,

  // ROB handshake
  input  logic     rob_ready_i,
  output logic     rob_valid_o,

  // Selection towards the payload mux
  output logic     served_max_prio_o,
  output eu_idx_t  served_idx_o
);

  // Requests still pending in the current round
  eu_mask_t snapshot_q;
  eu_mask_t snapshot_d;

  // Requests competing in this cycle
  eu_mask_t candidates;

  // Encoder result and its one-hot form
  eu_idx_t  enc_idx;
  logic     enc_valid;
  eu_mask_t grant;

  // ----------------------------------------------------------
  // Candidate selection
  // ----------------------------------------------------------

  // Live requests are sampled only once the round is over
  assign candidates = (|snapshot_q) ? snapshot_q : eu_valid_i;

  // Lowest candidate index goes first
  prio_enc_inv i_prio_enc (
    .lines_i (candidates),
    .enc_o   (enc_idx),
    .valid_o (enc_valid)
  );

  // Decode the winner into a one-hot grant
  always_comb begin : grant_dec
    grant = '0;
    if (enc_valid) begin
      grant[enc_idx] = 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Handshake outputs
  // ----------------------------------------------------------

  // Max-priority unit is never stalled
  assign max_prio_ready_o = 1'b1;

  // Bus carries a result when the override or any candidate is active
  assign rob_valid_o = max_prio_valid_i | enc_valid;

  // Granted unit sees ready only if the ROB takes its result now
  // and the max-priority unit is not holding the bus
  always_comb begin : ready_gen
    if (!max_prio_valid_i && rob_ready_i) begin
      eu_ready_o = grant;
    end else begin
      eu_ready_o = '0;
    end
  end

  // Payload selection
  assign served_max_prio_o = max_prio_valid_i;
  assign served_idx_o      = enc_idx;

  // ----------------------------------------------------------
  // Snapshot update
  // ----------------------------------------------------------

  // A line is retired only on an actual transfer, so a stalled
  // or overridden grant stays pending for the next cycle
  assign snapshot_d = candidates & ~eu_ready_o;

  // Flush wins over the normal update
  always_ff @(posedge clk_i or negedge rst_n_i) begin : snapshot_reg
    if (!rst_n_i) begin
      snapshot_q <= '0;
    end else if (flush_i) begin
      snapshot_q <= '0;
    end else begin
      snapshot_q <= snapshot_d;
    end
  end

endmodule

// File: logic/cdb_mux.sv
// CDB payload mux: puts the served unit's data, tag and exception on the bus
`timescale 1ns/1ps

module cdb_mux
  import cdb_pkg::*;
(
  // Max-priority unit payload
  input  cdb_data_t                max_prio_data_i,
  input  rob_tag_t                 max_prio_tag_i,
  input  logic                     max_prio_except_i,

  // Arbitrated unit payloads, one entry per unit
  input  cdb_data_t [EU_ARB_N-1:0] eu_data_i,
  input  rob_tag_t  [EU_ARB_N-1:0] eu_tag_i,
  input  eu_mask_t                 eu_except_i,

  // Selection from the arbiter
  input  logic                     served_max_prio_i,
  input  eu_idx_t                  served_idx_i,

  // Bus payload
  output cdb_data_t                cdb_data_o,
  output rob_tag_t                 cdb_tag_o,
  output logic                     cdb_except_o
);

  // Payload of the indexed unit
  cdb_data_t unit_data;
  rob_tag_t  unit_tag;
  logic      unit_except;

  // ----------------------------------------------------------
  // First level: indexed unit
  // ----------------------------------------------------------

  // Index always points at a real unit, the encoder
  // never produces an index past the last line
  always_comb begin : unit_sel
    unit_data   = eu_data_i[served_idx_i];
    unit_tag    = eu_tag_i[served_idx_i];
    unit_except = eu_except_i[served_idx_i];
  end

  // ----------------------------------------------------------
  // Second level: max-priority override
  // ----------------------------------------------------------

  // Bus valid is owned by the arbiter, so the payload is
  // passed on without any further qualification
  always_comb begin : override_sel
    if (served_max_prio_i) begin
      cdb_data_o   = max_prio_data_i;
      cdb_tag_o    = max_prio_tag_i;
      cdb_except_o = max_prio_except_i;
    end else begin
      cdb_data_o   = unit_data;
      cdb_tag_o    = unit_tag;
      cdb_except_o = unit_except;
    end
  end

endmodule

// File: logic/cdb_pkg.sv
// CDB types: result data, ROB tags, unit request masks and unit indices
`include "cdb_settings.svh"

package cdb_pkg;

  // ----------------------------------------------------------
  // Derived sizes
  // ----------------------------------------------------------

  // Units served in rounds, i.e. all but the max-priority one
  localparam int unsigned EU_ARB_N = `CDB_EU_N - 1;

  // Bits needed to index one arbitrated unit
  localparam int unsigned EU_IDX_W = (EU_ARB_N > 1) ? $clog2(EU_ARB_N) : 1;

  // ----------------------------------------------------------
  // Vector types
  // ----------------------------------------------------------

  // One result value as produced by a unit
  typedef logic [`CDB_DATA_W-1:0] cdb_data_t;

  // Reorder-buffer entry the result belongs to
  typedef logic [`CDB_TAG_W-1:0] rob_tag_t;

  // One bit per arbitrated unit
  typedef logic [EU_ARB_N-1:0] eu_mask_t;

  // Index of an arbitrated unit
  typedef logic [EU_IDX_W-1:0] eu_idx_t;

endpackage

// File: logic/cdb_settings.svh
// CDB sizing: number of execution units and the widths of the result fields
`ifndef CDB_SETTINGS_SVH
`define CDB_SETTINGS_SVH

// ----------------------------------------------------------
// Execution units
// ----------------------------------------------------------

// Total units on the bus, the max-priority one included
// Unit count above one leaves CDB_EU_N-1 units in the rounds
`define CDB_EU_N 5

// ----------------------------------------------------------
// Result fields
// ----------------------------------------------------------

// Width of one result value
`define CDB_DATA_W 32

// Width of a reorder-buffer entry tag
// Must cover every ROB entry
`define CDB_TAG_W 4

`endif

// File: logic/prio_enc_inv.sv
// Inverse priority encoder: the lowest set request line wins
`timescale 1ns/1ps

module prio_enc_inv
  import cdb_pkg::*;
(
  // Request lines, bit 0 has the highest priority
  input  eu_mask_t lines_i,
  // Index of the winning line, zero when none is set
  output eu_idx_t  enc_o,
  // High when at least one line is set
  output logic     valid_o
);

  // ----------------------------------------------------------
  // Encoder
  // ----------------------------------------------------------

  // Scan from the top down so that a lower set line
  // overwrites any higher one found before it
  always_comb begin : lowest_line_enc
    enc_o = '0;
    for (int i = EU_ARB_N - 1; i >= 0; i--) begin
      if (lines_i[i]) begin
        enc_o = eu_idx_t'(i);
      end
    end
  end

  // ----------------------------------------------------------
  // Any-line flag
  // ----------------------------------------------------------

  // Tells an empty set apart from a win of line 0
  assign valid_o = |lines_i;

endmodule

// File: test/cdb_checker.sv
// CDB checker: concurrent handshake properties, bound into the cdb top level
`timescale 1ns/1ps

module cdb_checker
  import cdb_pkg::*;
(
  input logic     clk_i,
  input logic     rst_n_i,
  input logic     max_prio_valid_i,
  input logic     max_prio_ready_i,
  input eu_mask_t eu_valid_i,
  input eu_mask_t eu_ready_i,
  input logic     rob_ready_i,
  input logic     rob_valid_i,
  // Pending requests of the current round
  input eu_mask_t snapshot_i
);

  // Number of failed properties, polled by the testbench
  int unsigned assert_fail_cnt = 0;

  // ----------------------------------------------------------
  // Handshake properties
  // ----------------------------------------------------------

  // Max-priority unit is never stalled
  mp_ready_high: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    max_prio_ready_i)
  else begin
    assert_fail_cnt = assert_fail_cnt + 1;
    $error("max_prio_ready_o dropped");
  end

  // At most one unit is granted per cycle
  eu_ready_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(eu_ready_i))
  else begin
    assert_fail_cnt = assert_fail_cnt + 1;
    $error("eu_ready_o has more than one bit set");
  end

  // No unit grant under override or ROB back-pressure
  eu_ready_blocked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (max_prio_valid_i || !rob_ready_i) |-> (eu_ready_i == '0))
  else begin
    assert_fail_cnt = assert_fail_cnt + 1;
    $error("eu_ready_o high during override or back-pressure");
  end

  // A ready only goes to a requesting unit
  eu_ready_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ((eu_ready_i & ~eu_valid_i) == '0))
  else begin
    assert_fail_cnt = assert_fail_cnt + 1;
    $error("eu_ready_o set for a unit without valid");
  end

  // Idle bus when nothing is requested or pending
  rob_valid_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (!max_prio_valid_i && eu_valid_i == '0 && snapshot_i == '0) |-> !rob_valid_i)
  else begin
    assert_fail_cnt = assert_fail_cnt + 1;
    $error("rob_valid_o high with no request");
  end

endmodule

// Snapshot is taken straight from the arbiter instance
bind cdb cdb_checker i_checker (
  .clk_i            (clk_i),
  .rst_n_i          (rst_n_i),
  .max_prio_valid_i (max_prio_valid_i),
  .max_prio_ready_i (max_prio_ready_o),
  .eu_valid_i       (eu_valid_i),
  .eu_ready_i       (eu_ready_o),
  .rob_ready_i      (rob_ready_i),
  .rob_valid_i      (rob_valid_o),
  .snapshot_i       (i_arbiter.snapshot_q)
);

// File: test/cdb_vectors.txt
# CDB cycle vectors, one clock cycle per line, all fields in hex
# flush mp_valid eu_valid rob_ready eu_seed mp_seed rob_valid eu_ready mp_ready data tag except
# Unit k carries data eu_seed+k, tag = low data bits, except = data bit 0
# Max-priority unit carries data mp_seed with tag and except taken the same way
# Data, tag and except are compared only on lines with rob_valid set
#
# Reset state, nothing requests
0 0 0 1 00000000 00000000 0 0 1 00000000 0 0
0 0 0 0 00000000 00000000 0 0 1 00000000 0 0
#
# Priority inside a round, units 0 2 3 served in index order
0 0 d 1 12345670 00000000 1 1 1 12345670 0 0
0 0 c 1 12345670 00000000 1 4 1 12345672 2 0
0 0 8 1 12345670 00000000 1 8 1 12345673 3 1
0 0 0 1 12345670 00000000 0 0 1 00000000 0 0
#
# Round fairness, units 0 and 1 raise mid-round and wait for the next round
0 0 e 1 22222220 00000000 1 2 1 22222221 1 1
0 0 f 1 22222220 00000000 1 4 1 22222222 2 0
0 0 b 1 22222220 00000000 1 8 1 22222223 3 1
0 0 3 1 22222220 00000000 1 1 1 22222220 0 0
0 0 2 1 22222220 00000000 1 2 1 22222221 1 1
0 0 0 1 22222220 00000000 0 0 1 00000000 0 0
#
# Max-priority override in mid-round, then the round resumes
0 0 7 1 33333330 00000000 1 1 1 33333330 0 0
0 1 6 1 33333330 abcd0125 1 0 1 abcd0125 5 1
0 1 6 1 33333330 abcd0125 1 0 1 abcd0125 5 1
0 0 6 1 33333330 00000000 1 2 1 33333331 1 1
0 0 4 1 33333330 00000000 1 4 1 33333332 2 0
0 0 0 1 33333330 00000000 0 0 1 00000000 0 0
# Override while the snapshot is empty, unit 3 is sampled and kept
0 1 8 1 33333330 abcd0126 1 0 1 abcd0126 6 0
0 0 8 1 33333330 00000000 1 8 1 33333333 3 1
#
# Back-pressure, unit 0 stays on the bus until the ROB is ready
0 0 5 0 44444440 00000000 1 0 1 44444440 0 0
0 0 5 0 44444440 00000000 1 0 1 44444440 0 0
0 0 5 0 44444440 00000000 1 0 1 44444440 0 0
0 0 5 1 44444440 00000000 1 1 1 44444440 0 0
0 0 4 0 44444440 00000000 1 0 1 44444442 2 0
0 0 4 1 44444440 00000000 1 4 1 44444442 2 0
0 0 0 1 44444440 00000000 0 0 1 00000000 0 0
#
# Flush in mid-round, live requests are sampled afresh on the next cycle
0 0 f 1 55555550 00000000 1 1 1 55555550 0 0
1 0 e 1 55555550 00000000 1 2 1 55555551 1 1
0 0 d 1 55555550 00000000 1 1 1 55555550 0 0
0 0 c 1 55555550 00000000 1 4 1 55555552 2 0
0 0 8 1 55555550 00000000 1 8 1 55555553 3 1
0 0 0 1 55555550 00000000 0 0 1 00000000 0 0

// File: test/tb_cdb.sv
// CDB testbench: replays per-cycle vectors from a file and compares the bus outputs
`timescale 1ns/1ps

module tb_cdb
  import cdb_pkg::*;
();

  localparam int    CLK_PERIOD     = 20;
  localparam int    RST_CYCLES     = 2;
  localparam int    TIMEOUT_MARGIN = 20;
  localparam string VEC_FILE       = "test/cdb_vectors.txt";

  // One line of the vector file
  typedef struct {
    logic      flush;
    logic      mp_valid;
    eu_mask_t  eu_valid;
    logic      rob_ready;
    cdb_data_t eu_seed;
    cdb_data_t mp_seed;
    logic      rob_valid;
    eu_mask_t  eu_ready;
    logic      mp_ready;
    cdb_data_t data;
    rob_tag_t  tag;
    logic      except_bit;
  } vector_t;

  // DUT ports
  logic                     clk_i;
  logic                     rst_n_i;
  logic                     flush_i;
  logic                     max_prio_valid_i;
  logic                     max_prio_ready_o;
  cdb_data_t                max_prio_data_i;
  rob_tag_t                 max_prio_tag_i;
  logic                     max_prio_except_i;
  eu_mask_t                 eu_valid_i;
  eu_mask_t                 eu_ready_o;
  cdb_data_t [EU_ARB_N-1:0] eu_data_i;
  rob_tag_t  [EU_ARB_N-1:0] eu_tag_i;
  eu_mask_t                 eu_except_i;
  logic                     rob_ready_i;
  logic                     rob_valid_o;
  cdb_data_t                cdb_data_o;
  rob_tag_t                 cdb_tag_o;
  logic                     cdb_except_o;

  vector_t     vectors[$];
  int          vec_idx     = 0;
  int unsigned cycle_cnt   = 0;
  int unsigned cycle_limit = 0;

  cdb i_dut (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .flush_i           (flush_i),
    .max_prio_valid_i  (max_prio_valid_i),
    .max_prio_ready_o  (max_prio_ready_o),
    .max_prio_data_i   (max_prio_data_i),
    .max_prio_tag_i    (max_prio_tag_i),
    .max_prio_except_i (max_prio_except_i),
    .eu_valid_i        (eu_valid_i),
    .eu_ready_o        (eu_ready_o),
    .eu_data_i         (eu_data_i),
    .eu_tag_i          (eu_tag_i),
    .eu_except_i       (eu_except_i),
    .rob_ready_i       (rob_ready_i),
    .rob_valid_o       (rob_valid_o),
    .cdb_data_o        (cdb_data_o),
    .cdb_tag_o         (cdb_tag_o),
    .cdb_except_o      (cdb_except_o)
  );

  // ----------------------------------------------------------
  // Clock and timeout
  // ----------------------------------------------------------

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Limit is armed once the vectors are loaded
  always @(posedge clk_i) begin : timeout_watch
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run went past %0d clock cycles", cycle_limit);
      $display("Test failed");
      $fatal(1);
    end
  end

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------

  task automatic check_bit(input string field, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t: vector %0d %s got %b expected %b",
               $time, vec_idx, field, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_mask(input string field, input eu_mask_t got, input eu_mask_t exp);
    if (got !== exp) begin
      $display("error at %0t: vector %0d %s got %h expected %h",
               $time, vec_idx, field, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_data(input string field, input cdb_data_t got, input cdb_data_t exp);
    if (got !== exp) begin
      $display("error at %0t: vector %0d %s got %h expected %h",
               $time, vec_idx, field, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_tag(input string field, input rob_tag_t got, input rob_tag_t exp);
    if (got !== exp) begin
      $display("error at %0t: vector %0d %s got %h expected %h",
               $time, vec_idx, field, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // ----------------------------------------------------------
  // Vector handling
  // ----------------------------------------------------------

  // Comment lines and blank lines are skipped
  task automatic load_vectors();
    int          fd;
    int          code;
    int          n;
    string       line;
    logic [31:0] fld [12];
    vector_t     v;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the vector file %s", VEC_FILE);
      $display("Test failed");
      $fatal(1);
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code != 0 && line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                      fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
                      fld[6], fld[7], fld[8], fld[9], fld[10], fld[11]);
          if (n == 12) begin
            v.flush      = fld[0][0];
            v.mp_valid   = fld[1][0];
            v.eu_valid   = eu_mask_t'(fld[2]);
            v.rob_ready  = fld[3][0];
            v.eu_seed    = cdb_data_t'(fld[4]);
            v.mp_seed    = cdb_data_t'(fld[5]);
            v.rob_valid  = fld[6][0];
            v.eu_ready   = eu_mask_t'(fld[7]);
            v.mp_ready   = fld[8][0];
            v.data       = cdb_data_t'(fld[9]);
            v.tag        = rob_tag_t'(fld[10]);
            v.except_bit = fld[11][0];
            vectors.push_back(v);
          end else if (n > 0) begin
            $display("Malformed line in the vector file: %s", line);
            $display("Test failed");
            $fatal(1);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Unit k gets seed plus k, tag and exception come from that value
  task automatic apply_vector(input vector_t v);
    flush_i           = v.flush;
    max_prio_valid_i  = v.mp_valid;
    eu_valid_i        = v.eu_valid;
    rob_ready_i       = v.rob_ready;
    max_prio_data_i   = v.mp_seed;
    max_prio_tag_i    = rob_tag_t'(v.mp_seed);
    max_prio_except_i = v.mp_seed[0];
    for (int k = 0; k < EU_ARB_N; k++) begin
      eu_data_i[k]   = v.eu_seed + cdb_data_t'(k);
      eu_tag_i[k]    = rob_tag_t'(eu_data_i[k]);
      eu_except_i[k] = eu_data_i[k][0];
    end
  endtask

  // Payload only matters while the bus is valid
  task automatic check_outputs(input vector_t v);
    check_bit("rob_valid_o", rob_valid_o, v.rob_valid);
    check_mask("eu_ready_o", eu_ready_o, v.eu_ready);
    check_bit("max_prio_ready_o", max_prio_ready_o, v.mp_ready);
    if (v.rob_valid) begin
      check_data("cdb_data_o", cdb_data_o, v.data);
      check_tag("cdb_tag_o", cdb_tag_o, v.tag);
      check_bit("cdb_except_o", cdb_except_o, v.except_bit);
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial begin : stimulus
    rst_n_i           = 1'b0;
    flush_i           = 1'b0;
    max_prio_valid_i  = 1'b0;
    max_prio_data_i   = '0;
    max_prio_tag_i    = '0;
    max_prio_except_i = 1'b0;
    eu_valid_i        = '0;
    eu_data_i         = '0;
    eu_tag_i          = '0;
    eu_except_i       = '0;
    rob_ready_i       = 1'b0;

    load_vectors();
    cycle_limit = vectors.size() + TIMEOUT_MARGIN;

    repeat (RST_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // Drive on the falling edge, compare just before the rising edge
    foreach (vectors[i]) begin
      @(negedge clk_i);
      vec_idx = i;
      apply_vector(vectors[i]);
      #(CLK_PERIOD / 2 - 1);
      check_outputs(vectors[i]);
      if (i_dut.i_checker.assert_fail_cnt != 0) begin
        $display("A handshake assertion failed before vector %0d", vec_idx);
        $display("Test failed");
        $fatal(1);
      end
    end

    // One more edge so the last vector is seen by the assertions
    @(posedge clk_i);
    #1;
    if (i_dut.i_checker.assert_fail_cnt == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("A handshake assertion failed on the last vector");
      $display("Test failed");
      $fatal(1);
    end
  end

endmodule
